//--- sources.f
+incdir+include
rtl/conv_pkg.sv
rtl/conv_weight_regs.sv
rtl/conv_tap_ctrl.sv
rtl/conv_mac_array.sv
rtl/conv_out_serializer.sv
rtl/conv_top.sv
verification/conv_properties.sv
verification/conv_tb.sv

//--- Makefile
TOP := conv_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

obj_dir/V$(TOP): sources.f $(wildcard rtl/*.sv verification/*.sv include/*.svh)
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- verification/conv_tb.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_tb;

        localparam int N_PASSES = 4;
        // worst case pass with up to 3 idle cycles before every beat
        localparam int PASS_MAX = `CONV_TAPS * 4;
        localparam int APB_MAX = 8 * `CONV_FILTERS * `CONV_TAPS + 16;
        localparam int WATCHDOG_CYCLES = 4 * (N_PASSES * (PASS_MAX + 16) + APB_MAX * 3);

        logic                  clk;
        logic                  rst;
        conv_pkg::apb_req_t    apb_req;
        conv_pkg::apb_rsp_t    apb_rsp;
        logic                  pix_valid;
        conv_pkg::pixel_vec_t  pix;
        logic                  res_valid;
        conv_pkg::result_t     res;

        logic [`CONV_WGT_W-1:0] wgt_model [`CONV_FILTERS][`CONV_TAPS];
        logic [`CONV_PIX_W-1:0] pix_data [2][`CONV_TAPS][`CONV_LANES];
        logic [`CONV_OUT_W-1:0] exp_res [2][`CONV_LANES][`CONV_FILTERS];
        int                     last_beat_cycle [2];
        int                     cycle_cnt = 0;

        conv_top i_dut (
                .clk       (clk),
                .rst       (rst),
                .apb_req   (apb_req),
                .apb_rsp   (apb_rsp),
                .pix_valid (pix_valid),
                .pix       (pix),
                .res_valid (res_valid),
                .res       (res)
        );

        initial begin
                clk = 1'b0;
                forever #20 clk = ~clk;
        end

        always @(posedge clk) begin
                cycle_cnt <= cycle_cnt + 1;
        end

        task automatic check_equal(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
                if (expected !== actual) begin
                        $display("ERR t=%0t %s expected=0x%0h actual=0x%0h",
                                 $time, name, expected, actual);
                        $display(">>> FAIL");
                        $fatal(1, "stopping at the first mismatch");
                end
        endtask

        task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                                 output logic err);
                @(posedge clk);
                #2;
                apb_req.psel    = 1'b1;
                apb_req.penable = 1'b0;
                apb_req.pwrite  = 1'b1;
                apb_req.paddr   = addr;
                apb_req.pwdata  = data;
                @(posedge clk);
                #2;
                apb_req.penable = 1'b1;
                @(negedge clk);
                check_equal("pready", 32'd1, 32'(apb_rsp.pready));
                err = apb_rsp.pslverr;
                @(posedge clk);
                #2;
                apb_req.psel    = 1'b0;
                apb_req.penable = 1'b0;
        endtask

        task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                                output logic err);
                @(posedge clk);
                #2;
                apb_req.psel    = 1'b1;
                apb_req.penable = 1'b0;
                apb_req.pwrite  = 1'b0;
                apb_req.paddr   = addr;
                @(posedge clk);
                #2;
                apb_req.penable = 1'b1;
                @(negedge clk);
                check_equal("pready", 32'd1, 32'(apb_rsp.pready));
                data = apb_rsp.prdata;
                err  = apb_rsp.pslverr;
                @(posedge clk);
                #2;
                apb_req.psel    = 1'b0;
                apb_req.penable = 1'b0;
        endtask

        // only the low byte of the data word is a weight
        task automatic load_weights();
                logic err;
                for (int f = 0; f < `CONV_FILTERS; f++) begin
                        for (int t = 0; t < `CONV_TAPS; t++) begin
                                apb_write(8'(f * `CONV_FILTER_STRIDE + t),
                                          {24'($urandom), wgt_model[f][t]}, err);
                                check_equal("pslverr on weight write", 32'd0, 32'(err));
                        end
                end
        endtask

        task automatic verify_weights();
                logic err;
                logic [31:0] data;
                logic [7:0] w;
                for (int f = 0; f < `CONV_FILTERS; f++) begin
                        for (int t = 0; t < `CONV_TAPS; t++) begin
                                apb_read(8'(f * `CONV_FILTER_STRIDE + t), data, err);
                                w = wgt_model[f][t];
                                check_equal($sformatf("prdata f%0d t%0d", f, t),
                                            {{24{w[7]}}, w}, data);
                                check_equal("pslverr on weight read", 32'd0, 32'(err));
                        end
                end
        endtask

        task automatic fill_pixels(input int slot);
                for (int t = 0; t < `CONV_TAPS; t++) begin
                        for (int l = 0; l < `CONV_LANES; l++) begin
                                pix_data[slot][t][l] = 8'($urandom);
                        end
                end
        endtask

        // bits 19..8 of the sum of pixel times signed weight
        task automatic compute_expected(input int slot);
                int acc;
                logic [31:0] acc_bits;
                for (int l = 0; l < `CONV_LANES; l++) begin
                        for (int f = 0; f < `CONV_FILTERS; f++) begin
                                acc = 0;
                                for (int t = 0; t < `CONV_TAPS; t++) begin
                                        acc += int'(pix_data[slot][t][l]) *
                                               int'($signed(wgt_model[f][t]));
                                end
                                acc_bits = 32'(acc);
                                exp_res[slot][l][f] = acc_bits[`CONV_OUT_LSB +: `CONV_OUT_W];
                        end
                end
        endtask

        // last beat stays on the bus until pix_idle
        task automatic run_pass(input int slot, input bit gaps);
                int idle;
                for (int t = 0; t < `CONV_TAPS; t++) begin
                        idle = gaps ? int'($urandom_range(3, 0)) : 0;
                        repeat (idle) begin
                                @(posedge clk);
                                #2;
                                pix_valid = 1'b0;
                                pix.lane  = {$urandom, $urandom};
                        end
                        @(posedge clk);
                        #2;
                        pix_valid = 1'b1;
                        for (int l = 0; l < `CONV_LANES; l++) begin
                                pix.lane[l] = pix_data[slot][t][l];
                        end
                        last_beat_cycle[slot] = cycle_cnt;
                end
        endtask

        task automatic pix_idle();
                @(posedge clk);
                #2;
                pix_valid = 1'b0;
        endtask

        task automatic collect_results(input int slot);
                @(negedge clk);
                while (!res_valid) begin
                        @(negedge clk);
                end
                check_equal("result start cycle", 32'(last_beat_cycle[slot] + 2),
                            32'(cycle_cnt));
                for (int l = 0; l < `CONV_LANES; l++) begin
                        check_equal("res_valid", 32'd1, 32'(res_valid));
                        check_equal("res.lane", 32'(l), 32'(res.lane));
                        for (int f = 0; f < `CONV_FILTERS; f++) begin
                                check_equal($sformatf("res.ch[%0d] lane %0d", f, l),
                                            32'(exp_res[slot][l][f]), 32'(res.ch[f]));
                        end
                        @(negedge clk);
                end
                check_equal("res_valid after drain", 32'd0, 32'(res_valid));
        endtask

        task automatic probe_unused_addr(input logic [7:0] addr);
                logic err;
                logic [31:0] data;
                apb_write(addr, 32'hffff_ff5a, err);
                check_equal($sformatf("pslverr write 0x%0h", addr), 32'd1, 32'(err));
                apb_read(addr, data, err);
                check_equal($sformatf("pslverr read 0x%0h", addr), 32'd1, 32'(err));
                check_equal($sformatf("prdata 0x%0h", addr), 32'd0, data);
        endtask

        task automatic readback_random_weights();
                for (int f = 0; f < `CONV_FILTERS; f++) begin
                        for (int t = 0; t < `CONV_TAPS; t++) begin
                                wgt_model[f][t] = 8'($urandom);
                        end
                end
                load_weights();
                verify_weights();
        endtask

        task automatic reject_unused_addresses();
                probe_unused_addr(8'd25);
                probe_unused_addr(8'd31);
                probe_unused_addr(8'd57);
                probe_unused_addr(8'd96);
                probe_unused_addr(8'd130);
                probe_unused_addr(8'd255);
                verify_weights();
        endtask

        task automatic unit_weight_pass();
                for (int f = 0; f < `CONV_FILTERS; f++) begin
                        for (int t = 0; t < `CONV_TAPS; t++) begin
                                wgt_model[f][t] = 8'd1;
                        end
                end
                load_weights();
                for (int t = 0; t < `CONV_TAPS; t++) begin
                        for (int l = 0; l < `CONV_LANES; l++) begin
                                pix_data[0][t][l] = 8'd64;
                        end
                end
                // 25 * 64 / 256
                for (int l = 0; l < `CONV_LANES; l++) begin
                        for (int f = 0; f < `CONV_FILTERS; f++) begin
                                exp_res[0][l][f] = 12'd6;
                        end
                end
                fork
                        begin
                                run_pass(0, 1'b0);
                                pix_idle();
                        end
                        collect_results(0);
                join
        endtask

        task automatic random_weight_pass();
                for (int f = 0; f < `CONV_FILTERS; f++) begin
                        for (int t = 0; t < `CONV_TAPS; t++) begin
                                wgt_model[f][t] = 8'($urandom);
                        end
                end
                wgt_model[2][0] = 8'h81;
                load_weights();
                fill_pixels(0);
                compute_expected(0);
                fork
                        begin
                                run_pass(0, 1'b0);
                                pix_idle();
                        end
                        collect_results(0);
                join
        endtask

        // second pass accumulates while the first one drains
        task automatic overlapped_passes();
                fill_pixels(0);
                fill_pixels(1);
                compute_expected(0);
                compute_expected(1);
                fork
                        begin
                                run_pass(0, 1'b1);
                                run_pass(1, 1'b0);
                                pix_idle();
                        end
                        begin
                                collect_results(0);
                                collect_results(1);
                        end
                join
        endtask

        initial begin
                void'($urandom(92866));
                rst       = 1'b1;
                apb_req   = '0;
                pix_valid = 1'b0;
                pix       = '0;
                repeat (2) @(posedge clk);
                #2;
                rst = 1'b0;
                readback_random_weights();
                reject_unused_addresses();
                unit_weight_pass();
                random_weight_pass();
                overlapped_passes();
                repeat (4) @(posedge clk);
                if (i_dut.i_props.fail_cnt != 0) begin
                        $display(">>> FAIL");
                        $fatal(1, "bound assertions on the DUT ports failed");
                end else begin
                        $display(">>> PASS");
                        $finish;
                end
        end

        initial begin
                repeat (WATCHDOG_CYCLES) @(posedge clk);
                $display("timeout, tests did not finish within %0d cycles", WATCHDOG_CYCLES);
                $display(">>> FAIL");
                $fatal(1, "watchdog expired");
        end

endmodule

//--- verification/conv_properties.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_properties (
        input logic                  clk,
        input logic                  rst,
        input conv_pkg::apb_req_t    apb_req,
        input conv_pkg::apb_rsp_t    apb_rsp,
        input logic                  res_valid,
        input conv_pkg::result_t     res
);

        localparam logic [3:0] LANES = 4'(`CONV_LANES);

        int fail_cnt = 0;
        // valid cycles seen so far in the current result run
        logic [3:0] run_len;

        always_ff @(posedge clk) begin
                if (rst) begin
                        run_len <= '0;
                end else if (res_valid) begin
                        run_len <= run_len + 4'd1;
                end else begin
                        run_len <= '0;
                end
        end

        a_pslverr_access: assert property (@(posedge clk) disable iff (rst)
                apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
                else begin
                        $error("pslverr outside an access cycle");
                        fail_cnt++;
                end

        a_run_not_long: assert property (@(posedge clk) disable iff (rst)
                res_valid |-> (run_len < LANES))
                else begin
                        $error("res_valid run longer than the lane count");
                        fail_cnt++;
                end

        a_run_not_short: assert property (@(posedge clk) disable iff (rst)
                (!res_valid && run_len != 4'd0) |-> (run_len == LANES))
                else begin
                        $error("res_valid run shorter than the lane count");
                        fail_cnt++;
                end

        a_lane_first: assert property (@(posedge clk) disable iff (rst)
                (res_valid && run_len == 4'd0) |-> (res.lane == '0))
                else begin
                        $error("result run does not start at lane 0");
                        fail_cnt++;
                end

        a_lane_step: assert property (@(posedge clk) disable iff (rst)
                (res_valid && run_len != 4'd0) |-> (res.lane == $past(res.lane) + 3'd1))
                else begin
                        $error("lane index did not step by one");
                        fail_cnt++;
                end

endmodule

bind conv_top conv_properties i_props (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .res_valid (res_valid),
        .res       (res)
);

//--- rtl/conv_top.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_top (
        input  logic                      clk,
        input  logic                      rst,
        input  conv_pkg::apb_req_t        apb_req,
        output conv_pkg::apb_rsp_t        apb_rsp,
        input  logic                      pix_valid,
        input  conv_pkg::pixel_vec_t      pix,
        output logic                      res_valid,
        output conv_pkg::result_t         res
);

        logic [`CONV_TAP_W-1:0] tap;
        conv_pkg::weight_set_t  weights;
        conv_pkg::mac_ctrl_t    mac_ctrl;
        conv_pkg::sum_set_t     sums;
        logic                   sums_done;

        conv_weight_regs i_weight_regs (
                .clk     (clk),
                .rst     (rst),
                .apb_req (apb_req),
                .apb_rsp (apb_rsp),
                .tap     (tap),
                .weights (weights)
        );

        conv_tap_ctrl i_tap_ctrl (
                .clk       (clk),
                .rst       (rst),
                .pix_valid (pix_valid),
                .tap       (tap),
                .mac_ctrl  (mac_ctrl)
        );

        // weights arrive in the same cycle as the beat
        conv_mac_array i_mac_array (
                .clk       (clk),
                .rst       (rst),
                .pix       (pix),
                .weights   (weights),
                .mac_ctrl  (mac_ctrl),
                .sums      (sums),
                .sums_done (sums_done)
        );

        conv_out_serializer i_out_serializer (
                .clk       (clk),
                .rst       (rst),
                .sums      (sums),
                .sums_done (sums_done),
                .res_valid (res_valid),
                .res       (res)
        );

endmodule

//--- rtl/conv_out_serializer.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_out_serializer (
        input  logic                      clk,
        input  logic                      rst,
        input  conv_pkg::sum_set_t        sums,
        input  logic                      sums_done,
        output logic                      res_valid,
        output conv_pkg::result_t         res
);

        localparam logic [`CONV_LANE_W-1:0] LAST_LANE = `CONV_LANE_W'(`CONV_LANES - 1);

        // scaled results of the pass being drained
        logic [`CONV_LANES-1:0][`CONV_FILTERS-1:0][`CONV_OUT_W-1:0] res_buf;
        logic [`CONV_LANE_W-1:0] lane_cnt;

        always_ff @(posedge clk) begin
                if (sums_done) begin
                        for (int l = 0; l < `CONV_LANES; l++) begin
                                for (int f = 0; f < `CONV_FILTERS; f++) begin
                                        res_buf[l][f] <= sums.acc[l][f][`CONV_OUT_LSB +: `CONV_OUT_W];
                                end
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        res_valid <= 1'b0;
                        lane_cnt  <= '0;
                end else if (sums_done) begin
                        res_valid <= 1'b1;
                        lane_cnt  <= '0;
                end else if (res_valid) begin
                        lane_cnt <= lane_cnt + 1'b1;
                        if (lane_cnt == LAST_LANE) begin
                                res_valid <= 1'b0;
                        end
                end
        end

        assign res.lane = lane_cnt;
        assign res.ch   = res_buf[lane_cnt];

endmodule

//--- rtl/conv_mac_array.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_mac_array (
        input  logic                      clk,
        input  logic                      rst,
        input  conv_pkg::pixel_vec_t      pix,
        input  conv_pkg::weight_set_t     weights,
        input  conv_pkg::mac_ctrl_t       mac_ctrl,
        output conv_pkg::sum_set_t        sums,
        output logic                      sums_done
);

        logic [`CONV_ACC_W-1:0] prod [`CONV_LANES][`CONV_FILTERS];

        // pixel zero-extended, weight sign-extended, low bits of the product are exact
        for (genvar l = 0; l < `CONV_LANES; l++) begin : g_lane
                for (genvar f = 0; f < `CONV_FILTERS; f++) begin : g_filt
                        assign prod[l][f] =
                                {{(`CONV_ACC_W - `CONV_PIX_W){1'b0}}, pix.lane[l]} *
                                {{(`CONV_ACC_W - `CONV_WGT_W){weights.wgt[f][`CONV_WGT_W-1]}},
                                 weights.wgt[f]};
                end
        end

        always_ff @(posedge clk) begin
                if (mac_ctrl.accum) begin
                        for (int l = 0; l < `CONV_LANES; l++) begin
                                for (int f = 0; f < `CONV_FILTERS; f++) begin
                                        // first tap loads, the rest add
                                        if (mac_ctrl.clear) begin
                                                sums.acc[l][f] <= prod[l][f];
                                        end else begin
                                                sums.acc[l][f] <= sums.acc[l][f] + prod[l][f];
                                        end
                                end
                        end
                end
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        sums_done <= 1'b0;
                end else begin
                        sums_done <= mac_ctrl.accum && mac_ctrl.last;
                end
        end

endmodule

//--- rtl/conv_tap_ctrl.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_tap_ctrl (
        input  logic                      clk,
        input  logic                      rst,
        input  logic                      pix_valid,
        output logic [`CONV_TAP_W-1:0]    tap,
        output conv_pkg::mac_ctrl_t       mac_ctrl
);

        localparam logic [`CONV_TAP_W-1:0] LAST_TAP = `CONV_TAP_W'(`CONV_TAPS - 1);

        conv_pkg::pass_state_e state;
        logic [`CONV_TAP_W-1:0] tap_cnt;

        always_ff @(posedge clk) begin
                if (rst) begin
                        state   <= conv_pkg::PASS_IDLE;
                        tap_cnt <= '0;
                end else if (pix_valid) begin
                        if (tap_cnt == LAST_TAP) begin
                                // pass complete, next beat opens a new one
                                state   <= conv_pkg::PASS_IDLE;
                                tap_cnt <= '0;
                        end else begin
                                state   <= conv_pkg::PASS_ACCUM;
                                tap_cnt <= tap_cnt + 1'b1;
                        end
                end
        end

        assign tap = tap_cnt;

        // every valid beat is accepted
        assign mac_ctrl.accum = pix_valid;
        assign mac_ctrl.clear = (state == conv_pkg::PASS_IDLE);
        assign mac_ctrl.last  = (tap_cnt == LAST_TAP);

endmodule

//--- rtl/conv_weight_regs.sv
`timescale 1ns/1ps
`include "conv_defines.svh"

module conv_weight_regs (
        input  logic                      clk,
        input  logic                      rst,
        input  conv_pkg::apb_req_t        apb_req,
        output conv_pkg::apb_rsp_t        apb_rsp,
        input  logic [`CONV_TAP_W-1:0]    tap,
        output conv_pkg::weight_set_t     weights
);

        localparam int FILT_IW = $clog2(`CONV_FILTERS);
        localparam int DATA_W = $bits(apb_rsp.prdata);

        logic [`CONV_WGT_W-1:0] wgt_mem [`CONV_FILTERS][`CONV_TAPS];

        logic [`CONV_ADDR_W-1:0] filt_idx;
        logic [`CONV_ADDR_W-1:0] tap_idx;
        logic [`CONV_WGT_W-1:0]  rd_wgt;
        logic                    access;
        logic                    addr_ok;

        // split the word address into filter and tap
        assign filt_idx = `CONV_ADDR_W'(apb_req.paddr / `CONV_FILTER_STRIDE);
        assign tap_idx  = `CONV_ADDR_W'(apb_req.paddr % `CONV_FILTER_STRIDE);
        assign addr_ok  = (filt_idx < `CONV_FILTERS) && (tap_idx < `CONV_TAPS);

        // no wait states, the access cycle completes at once
        assign access = apb_req.psel && apb_req.penable;

        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int f = 0; f < `CONV_FILTERS; f++) begin
                                for (int t = 0; t < `CONV_TAPS; t++) begin
                                        wgt_mem[f][t] <= '0;
                                end
                        end
                end else if (access && apb_req.pwrite && addr_ok) begin
                        wgt_mem[filt_idx[FILT_IW-1:0]][tap_idx[`CONV_TAP_W-1:0]] <=
                                apb_req.pwdata[`CONV_WGT_W-1:0];
                end
        end

        assign rd_wgt = wgt_mem[filt_idx[FILT_IW-1:0]][tap_idx[`CONV_TAP_W-1:0]];

        always_comb begin
                apb_rsp.pready  = access;
                apb_rsp.pslverr = access && !addr_ok;
                apb_rsp.prdata  = '0;
                if (access && !apb_req.pwrite && addr_ok) begin
                        // sign-extend to the bus width
                        apb_rsp.prdata = {{(DATA_W - `CONV_WGT_W){rd_wgt[`CONV_WGT_W-1]}},
                                          rd_wgt};
                end
        end

        // weights of the tap the controller is on
        always_comb begin
                for (int f = 0; f < `CONV_FILTERS; f++) begin
                        weights.wgt[f] = wgt_mem[f][tap];
                end
        end

endmodule

//--- rtl/conv_pkg.sv
`include "conv_defines.svh"

package conv_pkg;

        typedef enum logic {
                PASS_IDLE  = 1'b0,
                PASS_ACCUM = 1'b1
        } pass_state_e;

        // one unsigned pixel per lane
        typedef struct packed {
                logic [`CONV_LANES-1:0][`CONV_PIX_W-1:0] lane;
        } pixel_vec_t;

        // signed weights of the current tap, one per filter
        typedef struct packed {
                logic [`CONV_FILTERS-1:0][`CONV_WGT_W-1:0] wgt;
        } weight_set_t;

        typedef struct packed {
                logic accum;
                logic clear;
                logic last;
        } mac_ctrl_t;

        // signed accumulators, lane by filter
        typedef struct packed {
                logic [`CONV_LANES-1:0][`CONV_FILTERS-1:0][`CONV_ACC_W-1:0] acc;
        } sum_set_t;

        typedef struct packed {
                logic [`CONV_LANE_W-1:0] lane;
                logic [`CONV_FILTERS-1:0][`CONV_OUT_W-1:0] ch;
        } result_t;

        typedef struct packed {
                logic psel;
                logic penable;
                logic pwrite;
                logic [`CONV_ADDR_W-1:0] paddr;
                logic [31:0] pwdata;
        } apb_req_t;

        typedef struct packed {
                logic pready;
                logic pslverr;
                logic [31:0] prdata;
        } apb_rsp_t;

endpackage

//--- include/conv_defines.svh
`ifndef CONV_DEFINES_SVH
`define CONV_DEFINES_SVH

// engine geometry
`define CONV_LANES 8
`define CONV_TAPS 25
`define CONV_FILTERS 3

// datapath widths
`define CONV_PIX_W 8
`define CONV_WGT_W 8
`define CONV_ACC_W 20
`define CONV_OUT_LSB 8
`define CONV_OUT_W 12
`define CONV_TAP_W 5
`define CONV_LANE_W 3

// weight address map, word f * stride + t
`define CONV_ADDR_W 8
`define CONV_FILTER_STRIDE 32

`endif
